// File: rtl/cpu_arch_pkg.sv
`default_nettype none

package cpu_arch_pkg;

    typedef logic [63:0] data_t;        // execute result word
    typedef logic [31:0] eip_t;         // eip or linear address
    typedef logic [2:0]  reg_idx_t;     // gpr or segment index
    typedef logic [15:0] sel_t;         // segment selector
    typedef logic [31:0] gpr_t;
    typedef logic [3:0]  ie_type_t;     // bit 3 set for external interrupt

    localparam int NUM_ARCH_REGS = 8;   // per register file

    // destination of one result slot
    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_SEG  = 2'd2,
        DEST_MEM  = 2'd3
    } dest_kind_t;

endpackage

`default_nettype wire

// File: rtl/wb_cfg_pkg.sv
`default_nettype none

package wb_cfg_pkg;

    import cpu_arch_pkg::*;

    localparam int NUM_SLOTS  = 4;      // result slots per instruction
    localparam int WBAQ_DEPTH = 4;      // store queue entries
    localparam int WBAQ_PTR_W = $clog2(WBAQ_DEPTH);

    typedef logic [1:0] size_t;         // store size code

    localparam size_t    FAR_SIZE = 2'd3;   // far transfer pushes cs:eip
    localparam reg_idx_t CS_IDX   = 3'd1;

    localparam int LINE_BYTES = 16;     // fetch line
    localparam int LINE_SHIFT = $clog2(LINE_BYTES);

endpackage

`default_nettype wire

// File: rtl/wb_latch.sv
`timescale 1ns/1ps
`default_nettype none

module wb_latch
    import cpu_arch_pkg::*;
    import wb_cfg_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        stall,
    input  wire logic                        valid_in,
    input  wire data_t      [NUM_SLOTS-1:0]  slot_data,
    input  wire eip_t       [NUM_SLOTS-1:0]  slot_dest,
    input  wire dest_kind_t [NUM_SLOTS-1:0]  slot_kind,
    input  wire logic       [NUM_SLOTS-1:0]  slot_wb,
    input  wire size_t                       size,
    input  wire eip_t                        eip_next,
    input  wire logic                        br_valid,
    input  wire logic                        br_taken,
    input  wire logic                        br_correct,
    input  wire eip_t                        br_target,
    input  wire logic                        far_xfer,
    input  wire logic                        ie,
    input  wire ie_type_t                    ie_type,
    output logic                             stage_valid,
    output data_t           [NUM_SLOTS-1:0]  q_slot_data,
    output eip_t            [NUM_SLOTS-1:0]  q_slot_dest,
    output dest_kind_t      [NUM_SLOTS-1:0]  q_slot_kind,
    output logic            [NUM_SLOTS-1:0]  q_slot_wb,
    output size_t                            q_size,
    output eip_t                             q_eip_next,
    output logic                             q_br_valid,
    output logic                             q_br_taken,
    output logic                             q_br_correct,
    output eip_t                             q_br_target,
    output logic                             q_far_xfer,
    output logic                             q_ie,
    output ie_type_t                         q_ie_type
);

    // control part of the instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid  <= 1'b0;
            q_slot_wb    <= '0;
            q_br_valid   <= 1'b0;
            q_br_taken   <= 1'b0;
            q_br_correct <= 1'b0;
            q_far_xfer   <= 1'b0;
            q_ie         <= 1'b0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                q_slot_kind[i] <= DEST_NONE;
            end
        end else if (!stall) begin
            stage_valid  <= valid_in;   // bubble when execute is idle
            q_slot_kind  <= slot_kind;
            q_slot_wb    <= slot_wb;
            q_br_valid   <= br_valid;
            q_br_taken   <= br_taken;
            q_br_correct <= br_correct;
            q_far_xfer   <= far_xfer;
            q_ie         <= ie;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            q_slot_data <= slot_data;
            q_slot_dest <= slot_dest;
            q_size      <= size;
            q_eip_next  <= eip_next;
            q_br_target <= br_target;
            q_ie_type   <= ie_type;
        end
    end

endmodule

`default_nettype wire

// File: rtl/wb_slot.sv
`timescale 1ns/1ps
`default_nettype none

module wb_slot
    import cpu_arch_pkg::*;
(
    input  wire dest_kind_t slot_kind,
    input  wire logic       slot_wb,
    input  wire logic       commit_en,
    output logic            reg_we,
    output logic            seg_we,
    output logic            mem_hit
);

    always_comb begin
        reg_we  = 1'b0;
        seg_we  = 1'b0;
        mem_hit = 1'b0;
        if (slot_wb) begin
            case (slot_kind)
                DEST_REG: reg_we  = commit_en;
                DEST_SEG: seg_we  = commit_en;
                DEST_MEM: mem_hit = 1'b1;   // stall decision needs it ungated
                default:  ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/wb_commit.sv
`timescale 1ns/1ps
`default_nettype none

module wb_commit
    import cpu_arch_pkg::*;
    import wb_cfg_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   stage_valid,
    input  wire logic                   full,
    input  wire logic  [NUM_SLOTS-1:0]  reg_we,
    input  wire logic  [NUM_SLOTS-1:0]  seg_we,
    input  wire logic  [NUM_SLOTS-1:0]  mem_hit,
    input  wire data_t [NUM_SLOTS-1:0]  slot_data,
    input  wire eip_t  [NUM_SLOTS-1:0]  slot_dest,
    input  wire size_t                  size,
    input  wire logic                   far_xfer,
    input  wire reg_idx_t               gpr_rd_idx,
    input  wire reg_idx_t               seg_rd_idx,
    output logic                        commit_en,
    output logic                        stall,
    output logic                        push,
    output eip_t                        push_addr,
    output data_t                       push_data,
    output size_t                       push_size,
    output gpr_t                        gpr_rd_data,
    output sel_t                        seg_rd_data
);

    gpr_t gpr_file [NUM_ARCH_REGS];
    sel_t seg_file [NUM_ARCH_REGS];
    logic any_mem;

    assign any_mem   = |mem_hit;
    assign stall     = stage_valid & any_mem & full;    // wait for a free queue entry
    assign commit_en = stage_valid & ~stall;
    assign push      = commit_en & any_mem;
    assign push_size = far_xfer ? FAR_SIZE : size;

    // lowest memory slot carries the store
    always_comb begin
        push_addr = slot_dest[0];
        push_data = slot_data[0];
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                push_addr = slot_dest[i];
                push_data = slot_data[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpr_file <= '{default: '0};
            seg_file <= '{default: '0};
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin   // later slot overrides
                if (reg_we[i]) begin
                    gpr_file[slot_dest[i][2:0]] <= slot_data[i][31:0];
                end
                if (seg_we[i]) begin
                    seg_file[slot_dest[i][2:0]] <= slot_data[i][15:0];
                end
            end
            if (commit_en && far_xfer) begin
                seg_file[CS_IDX] <= slot_data[0][47:32];    // cs selector of far target
            end
        end
    end

    assign gpr_rd_data = gpr_file[gpr_rd_idx];
    assign seg_rd_data = seg_file[seg_rd_idx];

endmodule

`default_nettype wire

// File: rtl/wbaq.sv
`timescale 1ns/1ps
`default_nettype none

module wbaq
    import cpu_arch_pkg::*;
    import wb_cfg_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  push,
    input  wire eip_t  push_addr,
    input  wire data_t push_data,
    input  wire size_t push_size,
    input  wire logic  store_ack,
    output logic       full,
    output logic       store_valid,
    output eip_t       store_addr,
    output data_t      store_data,
    output size_t      store_size
);

    typedef logic [WBAQ_PTR_W-1:0] ptr_t;

    eip_t  addr_mem [WBAQ_DEPTH];
    data_t data_mem [WBAQ_DEPTH];
    size_t size_mem [WBAQ_DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    logic [WBAQ_PTR_W:0] count;

    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(WBAQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full        = (count == (WBAQ_PTR_W + 1)'(WBAQ_DEPTH));
    assign store_valid = (count != '0);
    assign store_addr  = addr_mem[rd_ptr];
    assign store_data  = data_mem[rd_ptr];
    assign store_size  = size_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (store_ack) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, store_ack})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
            size_mem[wr_ptr] <= push_size;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(store_ack && !store_valid))
        else $error("store ack with empty queue");

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full && !store_ack))
        else $error("push into full queue without a pop");

endmodule

`default_nettype wire

// File: rtl/wb_redirect.sv
`timescale 1ns/1ps
`default_nettype none

module wb_redirect
    import cpu_arch_pkg::*;
    import wb_cfg_pkg::*;
(
    input  wire logic     stage_valid,
    input  wire logic     br_valid,
    input  wire logic     br_taken,
    input  wire logic     br_correct,
    input  wire eip_t     br_target,
    input  wire eip_t     eip_next,
    input  wire logic     far_xfer,
    input  wire data_t    slot0_data,
    input  wire logic     ie,
    input  wire ie_type_t ie_type,
    input  wire logic     interrupt_in,
    output eip_t          new_eip,
    output eip_t          fetch_even,
    output eip_t          fetch_odd,
    output logic          resteer,
    output logic          ie_out,
    output ie_type_t      ie_type_out
);

    eip_t line_a;
    eip_t line_b;

    always_comb begin
        if (far_xfer) begin
            new_eip = slot0_data[31:0];     // far target eip
        end else if (br_taken) begin
            new_eip = br_target;
        end else begin
            new_eip = eip_next;
        end
    end

    assign resteer = stage_valid & (far_xfer | (br_valid & ~br_correct));

    // fetch unit wants the pair split by bank
    assign line_a     = new_eip & ~eip_t'(LINE_BYTES - 1);
    assign line_b     = line_a + eip_t'(LINE_BYTES);
    assign fetch_even = line_a[LINE_SHIFT] ? line_b : line_a;
    assign fetch_odd  = line_a[LINE_SHIFT] ? line_a : line_b;

    assign ie_out      = (stage_valid & ie) | interrupt_in;
    assign ie_type_out = interrupt_in ? {1'b1, ie_type[2:0]} : ie_type;

endmodule

`default_nettype wire

// File: rtl/writeback_top.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_top
    import cpu_arch_pkg::*;
    import wb_cfg_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        valid_in,
    input  wire data_t      [NUM_SLOTS-1:0]  slot_data,
    input  wire eip_t       [NUM_SLOTS-1:0]  slot_dest,
    input  wire dest_kind_t [NUM_SLOTS-1:0]  slot_kind,
    input  wire logic       [NUM_SLOTS-1:0]  slot_wb,
    input  wire size_t                       size,
    input  wire eip_t                        eip_next,
    input  wire logic                        br_valid,
    input  wire logic                        br_taken,
    input  wire logic                        br_correct,
    input  wire eip_t                        br_target,
    input  wire logic                        far_xfer,
    input  wire logic                        ie,
    input  wire ie_type_t                    ie_type,
    input  wire logic                        interrupt_in,
    input  wire logic                        store_ack,
    input  wire reg_idx_t                    gpr_rd_idx,
    input  wire reg_idx_t                    seg_rd_idx,
    output logic                             stall,
    output logic                             store_valid,
    output eip_t                             store_addr,
    output data_t                            store_data,
    output size_t                            store_size,
    output gpr_t                             gpr_rd_data,
    output sel_t                             seg_rd_data,
    output eip_t                             new_eip,
    output eip_t                             fetch_even,
    output eip_t                             fetch_odd,
    output logic                             resteer,
    output logic                             ie_out,
    output ie_type_t                         ie_type_out
);

    logic                        stage_valid;
    data_t      [NUM_SLOTS-1:0]  q_slot_data;
    eip_t       [NUM_SLOTS-1:0]  q_slot_dest;
    dest_kind_t [NUM_SLOTS-1:0]  q_slot_kind;
    logic       [NUM_SLOTS-1:0]  q_slot_wb;
    size_t                       q_size;
    eip_t                        q_eip_next;
    logic                        q_br_valid;
    logic                        q_br_taken;
    logic                        q_br_correct;
    eip_t                        q_br_target;
    logic                        q_far_xfer;
    logic                        q_ie;
    ie_type_t                    q_ie_type;
    logic       [NUM_SLOTS-1:0]  reg_we;
    logic       [NUM_SLOTS-1:0]  seg_we;
    logic       [NUM_SLOTS-1:0]  mem_hit;
    logic                        commit_en;
    logic                        full;
    logic                        push;
    eip_t                        push_addr;
    data_t                       push_data;
    size_t                       push_size;

    wb_latch u_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .valid_in    (valid_in),
        .slot_data   (slot_data),
        .slot_dest   (slot_dest),
        .slot_kind   (slot_kind),
        .slot_wb     (slot_wb),
        .size        (size),
        .eip_next    (eip_next),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_correct  (br_correct),
        .br_target   (br_target),
        .far_xfer    (far_xfer),
        .ie          (ie),
        .ie_type     (ie_type),
        .stage_valid (stage_valid),
        .q_slot_data (q_slot_data),
        .q_slot_dest (q_slot_dest),
        .q_slot_kind (q_slot_kind),
        .q_slot_wb   (q_slot_wb),
        .q_size      (q_size),
        .q_eip_next  (q_eip_next),
        .q_br_valid  (q_br_valid),
        .q_br_taken  (q_br_taken),
        .q_br_correct(q_br_correct),
        .q_br_target (q_br_target),
        .q_far_xfer  (q_far_xfer),
        .q_ie        (q_ie),
        .q_ie_type   (q_ie_type)
    );

    for (genvar g = 0; g < NUM_SLOTS; g++) begin : gen_slot
        wb_slot u_slot (
            .slot_kind(q_slot_kind[g]),
            .slot_wb  (q_slot_wb[g]),
            .commit_en(commit_en),
            .reg_we   (reg_we[g]),
            .seg_we   (seg_we[g]),
            .mem_hit  (mem_hit[g])
        );
    end

    wb_commit u_commit (
        .clk        (clk),
        .rst_n      (rst_n),
        .stage_valid(stage_valid),
        .full       (full),
        .reg_we     (reg_we),
        .seg_we     (seg_we),
        .mem_hit    (mem_hit),
        .slot_data  (q_slot_data),
        .slot_dest  (q_slot_dest),
        .size       (q_size),
        .far_xfer   (q_far_xfer),
        .gpr_rd_idx (gpr_rd_idx),
        .seg_rd_idx (seg_rd_idx),
        .commit_en  (commit_en),
        .stall      (stall),
        .push       (push),
        .push_addr  (push_addr),
        .push_data  (push_data),
        .push_size  (push_size),
        .gpr_rd_data(gpr_rd_data),
        .seg_rd_data(seg_rd_data)
    );

    wbaq u_wbaq (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_addr  (push_addr),
        .push_data  (push_data),
        .push_size  (push_size),
        .store_ack  (store_ack),
        .full       (full),
        .store_valid(store_valid),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_size (store_size)
    );

    wb_redirect u_redirect (
        .stage_valid (stage_valid),
        .br_valid    (q_br_valid),
        .br_taken    (q_br_taken),
        .br_correct  (q_br_correct),
        .br_target   (q_br_target),
        .eip_next    (q_eip_next),
        .far_xfer    (q_far_xfer),
        .slot0_data  (q_slot_data[0]),
        .ie          (q_ie),
        .ie_type     (q_ie_type),
        .interrupt_in(interrupt_in),   // taken straight from the pin
        .new_eip     (new_eip),
        .fetch_even  (fetch_even),
        .fetch_odd   (fetch_odd),
        .resteer     (resteer),
        .ie_out      (ie_out),
        .ie_type_out (ie_type_out)
    );

endmodule

`default_nettype wire

// File: test/writeback_tb.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_tb
    import cpu_arch_pkg::*;
    import wb_cfg_pkg::*;
();

    localparam int NUM_CASES   = 13;
    localparam int CYCLE_LIMIT = NUM_CASES * 40 + 20;

    typedef struct packed {
        dest_kind_t [0:NUM_SLOTS-1] kind;
        eip_t       [0:NUM_SLOTS-1] dest;
        logic       [0:NUM_SLOTS-1] wb;     // leftmost bit is slot 0
        size_t                      size;
        logic                       far;
        logic                       br_valid;
        logic                       br_taken;
        logic                       br_correct;
        eip_t                       br_target;
        eip_t                       eip_next;
        logic                       ie;
        ie_type_t                   ie_type;
        logic                       intr;
        logic [2:0]                 acks;   // store acks given after commit
    } row_t;

    logic clk;
    logic rst_n;
    logic valid_in;
    data_t      [NUM_SLOTS-1:0] slot_data;
    eip_t       [NUM_SLOTS-1:0] slot_dest;
    dest_kind_t [NUM_SLOTS-1:0] slot_kind;
    logic       [NUM_SLOTS-1:0] slot_wb;
    size_t    size;
    eip_t     eip_next;
    logic     br_valid;
    logic     br_taken;
    logic     br_correct;
    eip_t     br_target;
    logic     far_xfer;
    logic     ie;
    ie_type_t ie_type;
    logic     interrupt_in;
    logic     store_ack;
    reg_idx_t gpr_rd_idx;
    reg_idx_t seg_rd_idx;
    logic     stall;
    logic     store_valid;
    eip_t     store_addr;
    data_t    store_data;
    size_t    store_size;
    gpr_t     gpr_rd_data;
    sel_t     seg_rd_data;
    eip_t     new_eip;
    eip_t     fetch_even;
    eip_t     fetch_odd;
    logic     resteer;
    logic     ie_out;
    ie_type_t ie_type_out;

    // architectural state and store queue as the stage should leave them
    gpr_t  gpr_model [NUM_ARCH_REGS];
    sel_t  seg_model [NUM_ARCH_REGS];
    eip_t  q_addr [$];
    data_t q_data [$];
    size_t q_size [$];

    logic [31:0] rng_state = 32'h3903_d9a7;
    int    cycles = 0;
    int    errors = 0;
    int    case_errors;
    int    failed_cases = 0;
    string cur_name;

    string names [NUM_CASES] = '{"reg_all_slots", "wb_low_and_none", "same_dest_priority",
        "far_transfer", "store_lowest", "store_second", "store_third", "store_fourth",
        "backpressure", "mispredict_taken", "mispredict_fallthru", "correct_predict",
        "interrupt"};

    // kind, dest, wb, size, far, br valid/taken/correct, target, eip_next, ie, type, intr, acks
    row_t cases [NUM_CASES] = '{
        '{'{DEST_REG, DEST_REG, DEST_REG, DEST_REG}, '{32'd0, 32'd1, 32'd2, 32'd3}, 4'b1111,
          2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0100, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_REG, DEST_NONE, DEST_REG, DEST_SEG}, '{32'd4, 32'd5, 32'd6, 32'd2}, 4'b0110,
          2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0104, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_REG, DEST_REG, DEST_SEG, DEST_SEG}, '{32'd7, 32'd7, 32'd3, 32'd3}, 4'b1111,
          2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0108, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_NONE, DEST_MEM, DEST_SEG, DEST_REG}, '{32'd0, 32'h8000, 32'd1, 32'd5}, 4'b0111,
          2'd1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_010c, 1'b0, 4'h0, 1'b0, 3'd1},
        '{'{DEST_REG, DEST_MEM, DEST_MEM, DEST_NONE}, '{32'd2, 32'h9010, 32'h9020, 32'd0},
          4'b1110, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0110, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_MEM, DEST_NONE, DEST_NONE, DEST_NONE}, '{32'ha000, 32'd0, 32'd0, 32'd0},
          4'b1000, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0114, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_NONE, DEST_NONE, DEST_MEM, DEST_NONE}, '{32'd0, 32'd0, 32'ha100, 32'd0},
          4'b0010, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0118, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_MEM, DEST_REG, DEST_NONE, DEST_NONE}, '{32'ha200, 32'd4, 32'd0, 32'd0},
          4'b1100, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_011c, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_REG, DEST_MEM, DEST_NONE, DEST_NONE}, '{32'd4, 32'ha300, 32'd0, 32'd0},
          4'b1100, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0120, 1'b0, 4'h0, 1'b0, 3'd4},
        '{'{DEST_NONE, DEST_NONE, DEST_NONE, DEST_NONE}, '{32'd0, 32'd0, 32'd0, 32'd0}, 4'b0000,
          2'd0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h1238, 32'h0000_5000, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_NONE, DEST_NONE, DEST_NONE, DEST_NONE}, '{32'd0, 32'd0, 32'd0, 32'd0}, 4'b0000,
          2'd0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h7770, 32'h0000_2004, 1'b0, 4'h0, 1'b0, 3'd0},
        '{'{DEST_NONE, DEST_NONE, DEST_NONE, DEST_NONE}, '{32'd0, 32'd0, 32'd0, 32'd0}, 4'b0000,
          2'd0, 1'b0, 1'b1, 1'b1, 1'b1, 32'h3ffc, 32'h0000_6000, 1'b1, 4'h3, 1'b0, 3'd0},
        '{'{DEST_NONE, DEST_NONE, DEST_NONE, DEST_NONE}, '{32'd0, 32'd0, 32'd0, 32'd0}, 4'b0000,
          2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0000_0010, 1'b0, 4'h5, 1'b1, 3'd0}
    };

    writeback_top dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s, %s: expected %h, actual %h", cur_name, what,
                     expected, actual);
            case_errors++;
        end
    endtask

    // head of the queue must match before it is popped
    task automatic ack_one();
        @(negedge clk);
        if (q_addr.size() == 0) begin
            $display("Error in %s: a store ack was due but no store is expected", cur_name);
            case_errors++;
        end else begin
            check("store_valid", 1'b1, store_valid);
            check("store_addr", q_addr[0], store_addr);
            check("store_data", q_data[0], store_data);
            check("store_size", q_size[0], store_size);
            @(posedge clk);
            #1;
            store_ack = 1'b1;
            @(posedge clk);
            #1;
            store_ack = 1'b0;
            q_addr.delete(0);
            q_data.delete(0);
            q_size.delete(0);
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            gpr_rd_idx = reg_idx_t'(i);
            seg_rd_idx = reg_idx_t'(i);
            @(negedge clk);
            check($sformatf("gpr[%0d]", i), gpr_model[i], gpr_rd_data);
            check($sformatf("seg[%0d]", i), seg_model[i], seg_rd_data);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_case(input int idx);
        row_t  tc;
        data_t data [NUM_SLOTS];
        eip_t  exp_eip;
        eip_t  line_a;
        eip_t  line_b;
        logic  exp_stall;
        int    mem_slot;
        int    reg_slot;
        tc = cases[idx];
        cur_name = names[idx];
        case_errors = 0;
        mem_slot = -1;
        reg_slot = -1;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            rng_state = lcg_next(rng_state);
            data[i][63:32] = rng_state;
            rng_state = lcg_next(rng_state);
            data[i][31:0] = rng_state;
            if (tc.wb[i] && tc.kind[i] == DEST_MEM && mem_slot < 0) begin
                mem_slot = i;   // lowest memory slot stores
            end
            if (tc.wb[i] && tc.kind[i] == DEST_REG && reg_slot < 0) begin
                reg_slot = i;
            end
        end
        exp_stall = (mem_slot >= 0) && (q_addr.size() == WBAQ_DEPTH);

        @(posedge clk);
        #1;
        valid_in = 1'b1;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_data[i] = data[i];
            slot_dest[i] = tc.dest[i];
            slot_kind[i] = tc.kind[i];
            slot_wb[i]   = tc.wb[i];
        end
        size         = tc.size;
        far_xfer     = tc.far;
        br_valid     = tc.br_valid;
        br_taken     = tc.br_taken;
        br_correct   = tc.br_correct;
        br_target    = tc.br_target;
        eip_next     = tc.eip_next;
        ie           = tc.ie;
        ie_type      = tc.ie_type;
        interrupt_in = tc.intr;
        @(posedge clk);     // capture edge
        #1;
        valid_in = 1'b0;
        @(negedge clk);

        if (tc.far) begin
            exp_eip = data[0][31:0];
        end else if (tc.br_taken) begin
            exp_eip = tc.br_target;
        end else begin
            exp_eip = tc.eip_next;
        end
        line_a = {exp_eip[31:4], 4'h0};
        line_b = line_a + 32'd16;
        check("new_eip", exp_eip, new_eip);
        check("fetch_even", (line_a[4] == 1'b0) ? line_a : line_b, fetch_even);
        check("fetch_odd", (line_a[4] == 1'b0) ? line_b : line_a, fetch_odd);
        check("resteer", tc.far | (tc.br_valid & ~tc.br_correct), resteer);
        check("ie_out", tc.ie | tc.intr, ie_out);
        check("ie_type_out", {tc.ie_type[3] | tc.intr, tc.ie_type[2:0]}, ie_type_out);
        check("stall", exp_stall, stall);

        if (exp_stall) begin
            repeat (3) begin
                @(posedge clk);
                #1;
                if (reg_slot >= 0) begin
                    gpr_rd_idx = tc.dest[reg_slot][2:0];
                end
                @(negedge clk);
                check("stall held", 1'b1, stall);
                if (reg_slot >= 0) begin
                    check("gpr under stall", gpr_model[tc.dest[reg_slot][2:0]], gpr_rd_data);
                end
            end
            ack_one();
            @(negedge clk);
            while (stall) begin
                @(negedge clk);
            end
        end
        @(posedge clk);     // commit edge
        #1;
        interrupt_in = 1'b0;

        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (tc.wb[i] && tc.kind[i] == DEST_REG) begin
                gpr_model[tc.dest[i][2:0]] = data[i][31:0];
            end
            if (tc.wb[i] && tc.kind[i] == DEST_SEG) begin
                seg_model[tc.dest[i][2:0]] = data[i][15:0];
            end
        end
        if (tc.far) begin
            seg_model[1] = data[0][47:32];  // cs from the far pointer
        end
        if (mem_slot >= 0) begin
            q_addr.push_back(tc.dest[mem_slot]);
            q_data.push_back(data[mem_slot]);
            q_size.push_back(tc.far ? size_t'(3) : tc.size);
        end

        check_regs();
        for (int k = 0; k < tc.acks; k++) begin
            ack_one();
        end
        @(negedge clk);
        check("store_valid at end", q_addr.size() != 0, store_valid);

        if (case_errors == 0) begin
            $display("%-20s ok", cur_name);
        end else begin
            $display("%-20s %0d errors", cur_name, case_errors);
            failed_cases++;
        end
        errors += case_errors;
    endtask

    initial begin
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        slot_data    = '0;
        slot_dest    = '0;
        slot_kind    = '{default: DEST_NONE};
        slot_wb      = '0;
        size         = '0;
        eip_next     = '0;
        br_valid     = 1'b0;
        br_taken     = 1'b0;
        br_correct   = 1'b0;
        br_target    = '0;
        far_xfer     = 1'b0;
        ie           = 1'b0;
        ie_type      = '0;
        interrupt_in = 1'b0;
        store_ack    = 1'b0;
        gpr_rd_idx   = '0;
        seg_rd_idx   = '0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            gpr_model[i] = '0;
            seg_model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end

        $display("%0d tests run, %0d failing, %0d mismatches in total", NUM_CASES,
                 failed_cases, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: writeback_top.f
rtl/cpu_arch_pkg.sv
rtl/wb_cfg_pkg.sv
rtl/wb_latch.sv
rtl/wb_slot.sv
rtl/wb_commit.sv
rtl/wbaq.sv
rtl/wb_redirect.sv
rtl/writeback_top.sv
test/writeback_tb.sv
